// File: rtl/payload_config.svh
`ifndef PAYLOAD_CONFIG_SVH
`define PAYLOAD_CONFIG_SVH

// number of processing engines feeding the generator
`define NUM_PE 4

// stream beat width and beats per message
`define BEAT_W 64
`define NUM_BEATS 4

`define SYM_W 64

// the order number is sent as this many ASCII digits
`define ORDER_NO_DIGITS 5

`endif

// File: rtl/order_pkg.sv
`include "payload_config.svh"

package order_pkg;

    // codes follow the ASCII values used on the FIX wire
    typedef enum logic [7:0] {
        NEW     = 8'h30,
        CANCEL  = 8'h34,
        REPLACE = 8'h35
    } exec_type_e;

    typedef enum logic [7:0] {
        BUY  = 8'h31,
        SELL = 8'h32
    } side_e;

    typedef enum logic [7:0] {
        MARKET = 8'h31,
        LIMIT  = 8'h32
    } ord_type_e;

    typedef enum logic [7:0] {
        DAY = 8'h30,
        IOC = 8'h33,
        FOK = 8'h34
    } tif_e;

    typedef logic [31:0]       price_t;
    typedef logic [15:0]       qty_t;
    typedef logic [`SYM_W-1:0] symbol_t;

    typedef struct packed {
        exec_type_e exec_type;
        side_e      side;
        ord_type_e  ord_type;
        tif_e       tif;
        price_t     price;
        qty_t       qty;
        symbol_t    symbol;
    } order_t;

    // most significant digit sits in the top byte
    typedef logic [`ORDER_NO_DIGITS-1:0][7:0] order_no_t;

endpackage

// File: rtl/stream_pkg.sv
`include "payload_config.svh"

package stream_pkg;

    typedef logic [`BEAT_W-1:0] beat_t;

    typedef logic [$clog2(`NUM_PE)-1:0] pe_idx_t;

    // one state per beat on the wire plus idle
    typedef enum logic [2:0] {
        IDLE,
        HDR,
        BODY,
        SYM,
        TAIL
    } builder_state_e;

    typedef logic [15:0] session_id_t;
    typedef logic [31:0] seq_num_t;

endpackage

// File: rtl/arb_if.sv
`timescale 1ns/1ns
`include "payload_config.svh"

interface arb_if;
    import order_pkg::*;
    import stream_pkg::*;

    logic [`NUM_PE-1:0] req;
    order_t             order [`NUM_PE];
    logic               grant_valid;
    pe_idx_t            grant_idx;
    logic               busy;

    modport slots (
        output req,
        output order,
        input  grant_valid,
        input  grant_idx
    );

    modport arbiter (
        input  req,
        input  busy,
        output grant_valid,
        output grant_idx
    );

    modport builder (
        input  order,
        input  grant_valid,
        input  grant_idx,
        output busy
    );

endinterface

// File: rtl/order_slots.sv
`timescale 1ns/1ns
`include "payload_config.svh"

module order_slots (
    input  logic                clk,
    input  logic                resetn,
    input  logic [`NUM_PE-1:0]  pe_valid_i,
    input  order_pkg::order_t   pe_order_i [`NUM_PE],
    output logic [`NUM_PE-1:0]  pe_ready_o,
    arb_if.slots                arb
);
    import order_pkg::*;
    import stream_pkg::*;

    logic [`NUM_PE-1:0] full_q;
    order_t             slot_q [`NUM_PE];

    // an engine may hand over a new order only into an empty slot
    assign pe_ready_o = ~full_q;
    assign arb.req    = full_q;
    assign arb.order  = slot_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            full_q <= '0;
        end else begin
            for (int i = 0; i < `NUM_PE; i++) begin
                if (arb.grant_valid && arb.grant_idx == pe_idx_t'(i)) begin
                    full_q[i] <= 1'b0;
                end else if (pe_valid_i[i] && !full_q[i]) begin
                    full_q[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `NUM_PE; i++) begin
            if (pe_valid_i[i] && !full_q[i]) begin
                slot_q[i] <= pe_order_i[i];
            end
        end
    end

endmodule

// File: rtl/payload_arbiter.sv
`timescale 1ns/1ns
`include "payload_config.svh"

module payload_arbiter (
    input  logic    clk,
    input  logic    resetn,
    arb_if.arbiter  arb
);
    import stream_pkg::*;

    pe_idx_t ptr_q;
    pe_idx_t pick;
    logic    found;

    // first requesting slot at or after the pointer, wrapping around
    always_comb begin
        pe_idx_t idx;
        found = 1'b0;
        pick  = ptr_q;
        for (int k = 0; k < `NUM_PE; k++) begin
            idx = pe_idx_t'((int'(ptr_q) + k) % `NUM_PE);
            if (!found && arb.req[idx]) begin
                found = 1'b1;
                pick  = idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            arb.grant_valid <= 1'b0;
            arb.grant_idx   <= '0;
            ptr_q           <= '0;
        end else begin
            arb.grant_valid <= 1'b0;
            // a pending pulse blocks a second grant before busy rises
            if (!arb.busy && !arb.grant_valid && found) begin
                arb.grant_valid <= 1'b1;
                arb.grant_idx   <= pick;
                ptr_q           <= pe_idx_t'((int'(pick) + 1) % `NUM_PE);
            end
        end
    end

endmodule

// File: rtl/order_no_counter.sv
`timescale 1ns/1ns
`include "payload_config.svh"

module order_no_counter (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 advance_i,
    output order_pkg::order_no_t order_no_o
);
    import order_pkg::*;

    order_no_t                   digits_q;
    logic [`ORDER_NO_DIGITS-1:0] carry;

    // digit 0 is the least significant, each carry ripples on a nine
    always_comb begin
        carry[0] = advance_i;
        for (int d = 1; d < `ORDER_NO_DIGITS; d++) begin
            carry[d] = carry[d-1] && (digits_q[d-1] == "9");
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int d = 0; d < `ORDER_NO_DIGITS; d++) begin
                digits_q[d] <= "0";
            end
        end else begin
            for (int d = 0; d < `ORDER_NO_DIGITS; d++) begin
                if (carry[d]) begin
                    digits_q[d] <= (digits_q[d] == "9") ? "0" : digits_q[d] + 8'd1;
                end
            end
        end
    end

    assign order_no_o = digits_q;

endmodule

// File: rtl/payload_builder.sv
`timescale 1ns/1ns
`include "payload_config.svh"

module payload_builder (
    input  logic                   clk,
    input  logic                   resetn,
    arb_if.builder                 arb,
    input  stream_pkg::session_id_t session_id_i,
    input  stream_pkg::seq_num_t   msg_seq_num_i,
    input  order_pkg::order_no_t   order_no_i,
    input  logic                   tready_i,
    output logic                   tvalid_o,
    output logic                   tlast_o,
    output stream_pkg::beat_t      tdata_o
);
    import order_pkg::*;
    import stream_pkg::*;

    builder_state_e state_q;
    order_t         ord_q;
    session_id_t    session_q;
    seq_num_t       seq_q;
    order_no_t      order_no_q;
    order_t         sel_order;
    beat_t          beats [`NUM_BEATS];

    assign sel_order = arb.order[arb.grant_idx];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: if (arb.grant_valid) state_q <= HDR;
                HDR:  if (tready_i) state_q <= BODY;
                BODY: if (tready_i) state_q <= SYM;
                SYM:  if (tready_i) state_q <= TAIL;
                TAIL: if (tready_i) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // the message content is frozen at the grant so inputs may move on
    always_ff @(posedge clk) begin
        if (state_q == IDLE && arb.grant_valid) begin
            ord_q      <= sel_order;
            session_q  <= session_id_i;
            seq_q      <= msg_seq_num_i;
            order_no_q <= order_no_i;
        end
    end

    always_comb begin
        beats[0] = {session_q, ord_q.exec_type, ord_q.side, seq_q};
        beats[1] = {ord_q.price, ord_q.qty, ord_q.ord_type, ord_q.tif};
        beats[2] = ord_q.symbol;
        beats[3] = {order_no_q, 24'd0};
    end

    always_comb begin
        case (state_q)
            HDR:     tdata_o = beats[0];
            BODY:    tdata_o = beats[1];
            SYM:     tdata_o = beats[2];
            TAIL:    tdata_o = beats[3];
            default: tdata_o = '0;
        endcase
    end

    assign tvalid_o = (state_q != IDLE);
    assign tlast_o  = (state_q == TAIL);
    assign arb.busy = (state_q != IDLE);

endmodule

// File: rtl/top_payload_generator.sv
`timescale 1ns/1ns
`include "payload_config.svh"

module top_payload_generator (
    input  logic                    clk,
    input  logic                    resetn,
    input  stream_pkg::session_id_t session_id_i,
    input  stream_pkg::seq_num_t    msg_seq_num_i,
    input  logic [`NUM_PE-1:0]      pe_valid_i,
    input  order_pkg::order_t       pe_order_i [`NUM_PE],
    output logic [`NUM_PE-1:0]      pe_ready_o,
    input  logic                    tready_i,
    output logic                    tvalid_o,
    output logic                    tlast_o,
    output stream_pkg::beat_t       tdata_o
);
    import order_pkg::*;

    order_no_t order_no;

    arb_if arb ();

    order_slots u_slots (
        .clk        (clk),
        .resetn     (resetn),
        .pe_valid_i (pe_valid_i),
        .pe_order_i (pe_order_i),
        .pe_ready_o (pe_ready_o),
        .arb        (arb)
    );

    payload_arbiter u_arbiter (
        .clk    (clk),
        .resetn (resetn),
        .arb    (arb)
    );

    // the counter steps on the same edge the builder samples it
    order_no_counter u_order_no (
        .clk        (clk),
        .resetn     (resetn),
        .advance_i  (arb.grant_valid),
        .order_no_o (order_no)
    );

    payload_builder u_builder (
        .clk           (clk),
        .resetn        (resetn),
        .arb           (arb),
        .session_id_i  (session_id_i),
        .msg_seq_num_i (msg_seq_num_i),
        .order_no_i    (order_no),
        .tready_i      (tready_i),
        .tvalid_o      (tvalid_o),
        .tlast_o       (tlast_o),
        .tdata_o       (tdata_o)
    );

endmodule

// File: bench/tb_payload_generator.sv
`timescale 1ns/1ns
`include "payload_config.svh"

module tb_payload_generator;
    import order_pkg::*;
    import stream_pkg::*;

    localparam int          TOTAL_MSGS  = 105;
    localparam int          TIMEOUT_CYC = TOTAL_MSGS * 64 + 500;
    localparam session_id_t SESSION     = 16'h5a3c;
    localparam seq_num_t    SEQ_BASE    = 32'h0001_0000;

    logic               clk;
    logic               resetn;
    session_id_t        session_id_i;
    seq_num_t           msg_seq_num_i;
    logic [`NUM_PE-1:0] pe_valid_i;
    order_t             pe_order_i [`NUM_PE];
    logic [`NUM_PE-1:0] pe_ready_o;
    logic               tready_i;
    logic               tvalid_o;
    logic               tlast_o;
    beat_t              tdata_o;

    integer        seed;
    logic [1023:0] tready_pat;
    logic [31:0]   sym_cnt;
    int            tready_mode = 0;
    int            cycles = 0;
    int            msg_count = 0;
    int            main_errors = 0;
    int            main_checks = 0;
    int            mon_errors = 0;
    int            mon_checks = 0;
    int            beat_idx = 0;
    logic          hold_pend = 1'b0;
    logic          hold_last = 1'b0;
    beat_t         hold_data = '0;
    beat_t         beat_buf [`NUM_BEATS];
    order_t        pend_ord [$];
    int            pend_eng [$];
    int            used_idx [$];
    int            eng_log [$];

    top_payload_generator UUT (
        .clk           (clk),
        .resetn        (resetn),
        .session_id_i  (session_id_i),
        .msg_seq_num_i (msg_seq_num_i),
        .pe_valid_i    (pe_valid_i),
        .pe_order_i    (pe_order_i),
        .pe_ready_o    (pe_ready_o),
        .tready_i      (tready_i),
        .tvalid_o      (tvalid_o),
        .tlast_o       (tlast_o),
        .tdata_o       (tdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // four beats, beat 0 in the top 64 bits; the order number is num in decimal ASCII
    function automatic logic [255:0] ref_beats(input order_t o, input session_id_t sid,
                                               input seq_num_t seq, input int num);
        logic [39:0] ascii;
        int          n;
        n = num % 100000;
        for (int d = 0; d < 5; d++) begin
            ascii[8*d +: 8] = 8'h30 + 8'(n % 10);
            n = n / 10;
        end
        return {sid, o.exec_type, o.side, seq, o.price, o.qty, o.ord_type, o.tif,
                o.symbol, ascii, 24'd0};
    endfunction

    task automatic make_order(output order_t o);
        logic [31:0] r;
        r = $random(seed);
        case (r[1:0])
            2'd0:    o.exec_type = NEW;
            2'd1:    o.exec_type = CANCEL;
            default: o.exec_type = REPLACE;
        endcase
        o.side     = r[2] ? SELL : BUY;
        o.ord_type = r[3] ? LIMIT : MARKET;
        case (r[5:4])
            2'd0:    o.tif = DAY;
            2'd1:    o.tif = IOC;
            default: o.tif = FOK;
        endcase
        o.qty    = r[31:16];
        o.price  = $random(seed);
        // the low word is a running count so no two symbols match
        o.symbol = {$random(seed), sym_cnt};
        sym_cnt  = sym_cnt + 32'd1;
    endtask

    task automatic offer(input int e, input order_t o);
        @(posedge clk);
        #5;
        pe_valid_i[e] = 1'b1;
        pe_order_i[e] = o;
        pend_ord.push_back(o);
        pend_eng.push_back(e);
        @(negedge clk);
        while (!pe_ready_o[e]) @(negedge clk);
        @(posedge clk);
        #5;
        pe_valid_i[e] = 1'b0;
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (used_idx.size() != pend_ord.size() || tvalid_o || pe_ready_o != 4'hf) begin
            @(negedge clk);
        end
    endtask

    task automatic report(input string name, input int errs_before);
        if (main_errors + mon_errors == errs_before) $display("%s: ok", name);
        else $display("%s: failed", name);
    endtask

    task automatic check_message();
        int            found;
        bit            dup;
        logic [255:0]  exp;
        found = -1;
        dup   = 1'b0;
        for (int i = 0; i < pend_ord.size(); i++) begin
            if (pend_ord[i].symbol == beat_buf[2]) found = i;
        end
        foreach (used_idx[i]) begin
            if (used_idx[i] == found) dup = 1'b1;
        end
        mon_checks++;
        if (found < 0) begin
            mon_errors++;
            $display("message %0d carries symbol %h that was never sent", msg_count, beat_buf[2]);
        end else if (dup) begin
            mon_errors++;
            $display("message %0d repeats an order that already came out", msg_count);
        end else begin
            used_idx.push_back(found);
            eng_log.push_back(pend_eng[found]);
            exp = ref_beats(pend_ord[found], SESSION, SEQ_BASE + 32'(msg_count), msg_count);
            for (int k = 0; k < `NUM_BEATS; k++) begin
                mon_checks++;
                if (beat_buf[k] != exp[255 - 64*k -: 64]) begin
                    mon_errors++;
                    $display("Fail tdata_o beat %0d of message %0d: got %h expected %h",
                             k, msg_count, beat_buf[k], exp[255 - 64*k -: 64]);
                end
            end
        end
    endtask

    initial begin
        int k;
        tready_i      = 1'b1;
        session_id_i  = SESSION;
        msg_seq_num_i = SEQ_BASE;
        k = 0;
        forever begin
            @(posedge clk);
            #5;
            case (tready_mode)
                0:       tready_i = 1'b1;
                1:       tready_i = tready_pat[k % 1024];
                default: tready_i = 1'b0;
            endcase
            k++;
            // the next message's values are offered only while no message is out
            if (tvalid_o) begin
                session_id_i  = ~SESSION;
                msg_seq_num_i = ~(SEQ_BASE + 32'(msg_count));
            end else begin
                session_id_i  = SESSION;
                msg_seq_num_i = SEQ_BASE + 32'(msg_count);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYC) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("Simulation FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (resetn) begin
            if (hold_pend) begin
                mon_checks++;
                if (!tvalid_o) begin
                    mon_errors++;
                    $display("tvalid_o dropped before a stalled beat was taken");
                end else if (tdata_o != hold_data || tlast_o != hold_last) begin
                    mon_errors++;
                    $display("Fail tdata_o/tlast_o while stalled: got %h/%h expected %h/%h",
                             tdata_o, tlast_o, hold_data, hold_last);
                end
            end
            hold_pend = tvalid_o && !tready_i;
            hold_data = tdata_o;
            hold_last = tlast_o;
            if (tvalid_o && tready_i) begin
                beat_buf[beat_idx] = tdata_o;
                mon_checks++;
                if (tlast_o != (beat_idx == `NUM_BEATS - 1)) begin
                    mon_errors++;
                    $display("Fail tlast_o on beat %0d: got %h expected %h",
                             beat_idx, tlast_o, beat_idx == `NUM_BEATS - 1);
                end
                if (beat_idx == `NUM_BEATS - 1) begin
                    check_message();
                    beat_idx = 0;
                    msg_count++;
                end else begin
                    beat_idx++;
                end
            end
        end
    end

    initial begin
        order_t      o;
        logic [31:0] r;
        int          e0;
        int          first;
        int          start;
        int          single_eng;
        seed         = 32'h66b5;
        sym_cnt      = 32'd1;
        resetn       = 1'b0;
        pe_valid_i   = '0;
        single_eng   = 2;
        for (int e = 0; e < `NUM_PE; e++) begin
            pe_order_i[e] = '0;
        end
        for (int k = 0; k < 32; k++) begin
            tready_pat[32*k +: 32] = $random(seed);
        end
        repeat (2) @(posedge clk);
        #5;
        resetn = 1'b1;

        e0 = 0;
        @(negedge clk);
        main_checks++;
        if (tvalid_o || tlast_o) begin
            main_errors++;
            $display("Fail tvalid_o/tlast_o after reset: got %h/%h expected 0/0",
                     tvalid_o, tlast_o);
        end
        if (pe_ready_o != 4'hf) begin
            main_errors++;
            $display("Fail pe_ready_o after reset: got %h expected %h", pe_ready_o, 4'hf);
        end
        report("reset", e0);

        e0 = main_errors + mon_errors;
        make_order(o);
        offer(single_eng, o);
        wait_idle();
        main_checks++;
        if (msg_count != 1 || eng_log[$] != single_eng) begin
            main_errors++;
            $display("single order: expected one message from engine %0d, saw %0d",
                     single_eng, msg_count);
        end
        report("single order", e0);

        // all four slots fill on one edge; grants start after the last granted engine
        e0    = main_errors + mon_errors;
        start = eng_log.size();
        first = (single_eng + 1) % `NUM_PE;
        @(posedge clk);
        #5;
        for (int e = 0; e < `NUM_PE; e++) begin
            make_order(o);
            pe_order_i[e] = o;
            pend_ord.push_back(o);
            pend_eng.push_back(e);
        end
        pe_valid_i = 4'hf;
        @(posedge clk);
        #5;
        pe_valid_i = '0;
        wait_idle();
        for (int k = 0; k < `NUM_PE; k++) begin
            main_checks++;
            if (eng_log[start + k] != (first + k) % `NUM_PE) begin
                main_errors++;
                $display("round robin: message %0d came from engine %0d, expected engine %0d",
                         start + k, eng_log[start + k], (first + k) % `NUM_PE);
            end
        end
        report("round robin", e0);

        e0 = main_errors + mon_errors;
        tready_mode = 1;
        for (int n = 0; n < 8; n++) begin
            r = $random(seed);
            make_order(o);
            offer(int'(r[1:0]), o);
        end
        wait_idle();
        tready_mode = 0;
        report("back-pressure", e0);

        // hold the stream so the second slot stays full while a new order is offered
        e0 = main_errors + mon_errors;
        tready_mode = 2;
        make_order(o);
        offer(0, o);
        make_order(o);
        offer(1, o);
        repeat (2) @(posedge clk);
        #5;
        make_order(o);
        pe_order_i[1] = o;
        pe_valid_i[1] = 1'b1;
        repeat (6) begin
            @(negedge clk);
            main_checks++;
            if (pe_ready_o[1]) begin
                main_errors++;
                $display("Fail pe_ready_o[1] with a full slot: got %h expected %h", 1'b1, 1'b0);
            end
        end
        @(posedge clk);
        #5;
        pe_valid_i[1] = 1'b0;
        tready_mode = 0;
        wait_idle();
        report("slot full", e0);

        e0 = main_errors + mon_errors;
        for (int n = 0; n < 90; n++) begin
            make_order(o);
            offer(n % `NUM_PE, o);
        end
        wait_idle();
        main_checks++;
        if (msg_count != TOTAL_MSGS) begin
            main_errors++;
            $display("decimal carry: %0d messages came out, expected %0d", msg_count, TOTAL_MSGS);
        end
        report("decimal carry", e0);

        $display("checks %0d, errors %0d, messages %0d", main_checks + mon_checks,
                 main_errors + mon_errors, msg_count);
        if (main_errors + mon_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+rtl
rtl/order_pkg.sv
rtl/stream_pkg.sv
rtl/arb_if.sv
rtl/order_slots.sv
rtl/payload_arbiter.sv
rtl/order_no_counter.sv
rtl/payload_builder.sv
rtl/top_payload_generator.sv
bench/tb_payload_generator.sv

// File: run_sim.sh
#!/bin/sh
LOG=sim.log

if ! verilator --binary --timing --timescale 1ns/1ns -f tb.f \
        --top-module tb_payload_generator -o sim_tb; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation PASSED" "$LOG"; then
    exit 0
fi
exit 1
